// ==== run_sim.sh ====
#!/bin/sh
# build and run the scope testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  -f scope_top.f --top-module scope_tb -o scope_sim
./obj_dir/scope_sim > sim.log
cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log

// ==== scope_top.f ====
source/scope_pkg.sv
source/scope_regs.sv
source/scope_dec_avg.sv
source/scope_edge.sv
source/scope_acq.sv
source/scope_top.sv
verif/scope_tb.sv

// ==== source/scope_acq.sv ====
//////////////////////////////
// acquisition controller
// arm/trigger with pre and post
// counters, timestamps of start,
// trigger and stop, stream forward
//////////////////////////////

`timescale 1ns/1ps

module scope_acq #(
  parameter int unsigned CW = 17,
  parameter int unsigned TN = 4,
  parameter int unsigned TW = 64
) (
  input  logic            bus,
  input  logic            rst_n,
  input  scope_pkg::smp_t sti,
  output scope_pkg::smp_t sto,
  input  logic            ctl_rst,
  input  logic            ctl_acq,
  input  logic            ctl_stp,
  input  logic [TN+1:0]   trg_src,
  input  logic [TN+1:0]   cfg_trg,
  input  logic            cfg_con,
  input  logic [CW-1:0]   cfg_pre,
  input  logic [CW-1:0]   cfg_pst,
  output logic            sts_acq,
  output logic            sts_trg,
  output logic [CW-1:0]   sts_pre,
  output logic [CW-1:0]   sts_pst,
  output logic [TW-1:0]   cts_acq,
  output logic [TW-1:0]   cts_trg,
  output logic [TW-1:0]   cts_stp
);

  logic [TW-1:0]                      cts;
  logic                               trg;
  logic                               armed;
  logic                               pst_done;
  logic                               fwd;
  logic                               vld_q;
  logic signed [scope_pkg::smp_w-1:0] dat_q;

  // free-running time
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cts <= '0;
    end else begin
      cts <= cts + 1'b1;
    end
  end

  // masked trigger sources
  assign trg      = |(trg_src & cfg_trg);
  // pre-trigger window filled
  assign armed    = sts_acq && !sts_trg && (sts_pre == cfg_pre);
  // post-trigger window filled, ignored in continuous mode
  assign pst_done = sts_trg && !cfg_con && (sts_pst == cfg_pst);
  assign fwd      = sts_acq && !pst_done;

  //////////////////////////////
  // acquisition state
  //////////////////////////////
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
      cts_acq <= '0;
      cts_trg <= '0;
      cts_stp <= '0;
    end else if (ctl_rst) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
    end else if (ctl_acq) begin
      // start, counters from zero
      sts_acq <= 1'b1;
      sts_trg <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
      cts_acq <= cts;
    end else if (sts_acq) begin
      if (ctl_stp || pst_done) begin
        sts_acq <= 1'b0;
        cts_stp <= cts;
      end else if (armed && trg) begin
        sts_trg <= 1'b1;
        cts_trg <= cts;
      end
      // pre count saturates at cfg_pre
      if (sti.vld && !sts_trg && (sts_pre != cfg_pre)) begin
        sts_pre <= sts_pre + 1'b1;
      end
      if (sti.vld && sts_trg && !pst_done) begin
        sts_pst <= sts_pst + 1'b1;
      end
    end
  end

  // forward beats while acquiring
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= sti.vld & fwd & ~ctl_rst;
    end
  end

  always_ff @(posedge bus) begin
    dat_q <= sti.dat;
  end

  assign sto.vld = vld_q;
  assign sto.dat = dat_q;

  // post count bounded outside continuous mode
  a_pst_bound: assert property (@(posedge bus) disable iff (!rst_n)
    sts_acq && !cfg_con |-> sts_pst <= cfg_pst);

endmodule

// ==== source/scope_dec_avg.sv ====
//////////////////////////////
// decimator, one beat per group
// of N input beats, optional
// sum-and-shift averaging
//////////////////////////////

`timescale 1ns/1ps

module scope_dec_avg #(
  parameter int unsigned DCW = 17,
  parameter int unsigned DSW = 4
) (
  input  logic                bus,
  input  logic                rst_n,
  input  logic                ctl_rst,
  input  logic                cfg_avg,
  input  logic [DCW-1:0]      cfg_dec,
  input  logic [DSW-1:0]      cfg_shr,
  input  scope_pkg::smp_t     sti,
  output scope_pkg::smp_t     sto
);

  // sum of up to 2^DCW samples fits here
  localparam int unsigned SUMW = scope_pkg::smp_w + DCW;

  logic [DCW-1:0]                    dec_n;
  logic [DCW-1:0]                    cnt_q;
  logic                              cnt_lst;
  logic signed [SUMW-1:0]            sum_q;
  logic signed [SUMW-1:0]            sum_nxt;
  logic signed [SUMW-1:0]            sum_shr;
  logic                              vld_q;
  logic signed [scope_pkg::smp_w-1:0] dat_q;

  // zero factor behaves as one
  assign dec_n   = (cfg_dec == '0) ? DCW'(1) : cfg_dec;
  assign cnt_lst = (cnt_q == dec_n - 1'b1);

  // running sum including current beat
  assign sum_nxt = sum_q + $signed(sti.dat);
  assign sum_shr = sum_nxt >>> cfg_shr;

  // group counter and accumulator
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      sum_q <= '0;
      vld_q <= 1'b0;
    end else if (ctl_rst) begin
      // fresh group
      cnt_q <= '0;
      sum_q <= '0;
      vld_q <= 1'b0;
    end else begin
      vld_q <= sti.vld & cnt_lst;
      if (sti.vld) begin
        if (cnt_lst) begin
          cnt_q <= '0;
          sum_q <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
          sum_q <= sum_nxt;
        end
      end
    end
  end

  // output sample, truncated average or last sample
  always_ff @(posedge bus) begin
    if (sti.vld && cnt_lst) begin
      dat_q <= cfg_avg ? sum_shr[scope_pkg::smp_w-1:0] : sti.dat;
    end
  end

  assign sto.vld = vld_q;
  assign sto.dat = dat_q;

  // one output beat per group
  a_no_back_to_back: assert property (@(posedge bus) disable iff (!rst_n)
    (cfg_dec > DCW'(1)) && sto.vld |=> !sto.vld);

endmodule

// ==== source/scope_edge.sv ====
//////////////////////////////
// rising edge detector with level
// and hysteresis, Schmitt style,
// on the decimated stream
//////////////////////////////

`timescale 1ns/1ps

module scope_edge (
  input  logic                               bus,
  input  logic                               rst_n,
  input  logic                               ctl_rst,
  input  logic signed [scope_pkg::smp_w-1:0] cfg_lvl,
  input  logic [scope_pkg::smp_w-1:0]        cfg_hst,
  input  scope_pkg::smp_t                    str,
  output logic                               trg_out
);

  // two extra bits so level minus hysteresis cannot wrap
  localparam int unsigned XW = scope_pkg::smp_w + 2;

  logic signed [XW-1:0] thr_lo;
  logic signed [XW-1:0] thr_hi;
  logic signed [XW-1:0] smp;
  logic                 below;
  logic                 above;
  logic                 armed_q;

  assign thr_hi = XW'(cfg_lvl);
  assign thr_lo = thr_hi - $signed({2'b00, cfg_hst});
  assign smp    = XW'(str.dat);

  // arm below the lower threshold
  assign below = (smp < thr_lo);
  // fire at or above the level
  assign above = (smp >= thr_hi);

  //////////////////////////////
  // arm and fire
  //////////////////////////////
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      armed_q <= 1'b0;
      trg_out <= 1'b0;
    end else if (ctl_rst) begin
      armed_q <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      // strobe lasts one cycle
      trg_out <= 1'b0;
      if (str.vld) begin
        if (armed_q && above) begin
          trg_out <= 1'b1;
          armed_q <= 1'b0;
        end else if (below) begin
          armed_q <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/scope_pkg.sv ====
//////////////////////////////
// shared definitions for the scope
// sample stream beat, system bus
// request and response, register map
// and control word bit positions
//////////////////////////////

package scope_pkg;

  // sample width
  localparam int unsigned smp_w = 14;

  // one stream beat, no back-pressure
  typedef struct packed {
    logic                    vld;
    logic signed [smp_w-1:0] dat;
  } smp_t;

  // system bus widths
  localparam int unsigned bus_aw = 7;
  localparam int unsigned bus_dw = 32;

  // single-cycle request from the master
  typedef struct packed {
    logic              wen;
    logic              ren;
    logic [bus_aw-1:0] addr;
    logic [bus_dw-1:0] wdata;
  } bus_req_t;

  // response, one cycle after the request
  typedef struct packed {
    logic              ack;
    logic [bus_dw-1:0] rdata;
  } bus_rsp_t;

  //////////////////////////////
  // register offsets
  //////////////////////////////
  localparam logic [bus_aw-1:0] reg_ctl        = 7'h00;
  localparam logic [bus_aw-1:0] reg_cfg        = 7'h04;
  localparam logic [bus_aw-1:0] reg_trg        = 7'h08;
  localparam logic [bus_aw-1:0] reg_pre        = 7'h10;
  localparam logic [bus_aw-1:0] reg_pst        = 7'h14;
  localparam logic [bus_aw-1:0] reg_sts_pre    = 7'h18;
  localparam logic [bus_aw-1:0] reg_sts_pst    = 7'h1c;
  localparam logic [bus_aw-1:0] reg_cts_acq_lo = 7'h20;
  localparam logic [bus_aw-1:0] reg_cts_acq_hi = 7'h24;
  localparam logic [bus_aw-1:0] reg_cts_trg_lo = 7'h28;
  localparam logic [bus_aw-1:0] reg_cts_trg_hi = 7'h2c;
  localparam logic [bus_aw-1:0] reg_cts_stp_lo = 7'h30;
  localparam logic [bus_aw-1:0] reg_cts_stp_hi = 7'h34;
  localparam logic [bus_aw-1:0] reg_lvl        = 7'h50;
  localparam logic [bus_aw-1:0] reg_hst        = 7'h54;
  localparam logic [bus_aw-1:0] reg_avg        = 7'h60;
  localparam logic [bus_aw-1:0] reg_dec        = 7'h64;
  localparam logic [bus_aw-1:0] reg_shr        = 7'h68;

  // bits of the control word at reg_ctl
  localparam int unsigned ctl_bit_rst = 0;
  localparam int unsigned ctl_bit_acq = 1;
  localparam int unsigned ctl_bit_stp = 2;
  localparam int unsigned ctl_bit_trg = 3;

endpackage

// ==== source/scope_regs.sv ====
//////////////////////////////
// register slave on the system bus
// configuration registers, control
// strobes from the control word and
// registered status readback
//////////////////////////////

`timescale 1ns/1ps

module scope_regs #(
  parameter int unsigned DCW = 17,
  parameter int unsigned DSW = 4,
  parameter int unsigned CW  = 17,
  parameter int unsigned TN  = 4,
  parameter int unsigned TW  = 64
) (
  input  logic                                bus,
  input  logic                                rst_n,
  input  scope_pkg::bus_req_t                 bus_req,
  output scope_pkg::bus_rsp_t                 bus_rsp,
  // configuration
  output logic                                cfg_con,
  output logic [TN+1:0]                       cfg_trg,
  output logic [CW-1:0]                       cfg_pre,
  output logic [CW-1:0]                       cfg_pst,
  output logic signed [scope_pkg::smp_w-1:0]  cfg_lvl,
  output logic [scope_pkg::smp_w-1:0]         cfg_hst,
  output logic                                cfg_avg,
  output logic [DCW-1:0]                      cfg_dec,
  output logic [DSW-1:0]                      cfg_shr,
  // control strobes
  output logic                                ctl_rst,
  output logic                                ctl_acq,
  output logic                                ctl_stp,
  output logic                                trg_swo,
  // status and timestamps
  input  logic                                sts_acq,
  input  logic                                sts_trg,
  input  logic [CW-1:0]                       sts_pre,
  input  logic [CW-1:0]                       sts_pst,
  input  logic [TW-1:0]                       cts_acq,
  input  logic [TW-1:0]                       cts_trg,
  input  logic [TW-1:0]                       cts_stp
);

  localparam int unsigned DW = scope_pkg::bus_dw;

  logic          wr_ctl;
  logic          ack_q;
  logic [DW-1:0] rdata_q;
  logic [DW-1:0] rd_mux;

  //////////////////////////////
  // control strobes
  //////////////////////////////
  // combinational, same cycle as wen
  assign wr_ctl  = bus_req.wen && (bus_req.addr == scope_pkg::reg_ctl);
  assign ctl_rst = wr_ctl & bus_req.wdata[scope_pkg::ctl_bit_rst];
  assign ctl_acq = wr_ctl & bus_req.wdata[scope_pkg::ctl_bit_acq];
  assign ctl_stp = wr_ctl & bus_req.wdata[scope_pkg::ctl_bit_stp];
  assign trg_swo = wr_ctl & bus_req.wdata[scope_pkg::ctl_bit_trg];

  // write decode, fields masked to width
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cfg_con <= 1'b0;
      cfg_trg <= '0;
      cfg_pre <= '0;
      cfg_pst <= '0;
      cfg_lvl <= '0;
      cfg_hst <= '0;
      cfg_avg <= 1'b0;
      cfg_dec <= '0;
      cfg_shr <= '0;
    end else if (bus_req.wen) begin
      case (bus_req.addr)
        scope_pkg::reg_cfg: cfg_con <= bus_req.wdata[0];
        scope_pkg::reg_trg: cfg_trg <= bus_req.wdata[TN+1:0];
        scope_pkg::reg_pre: cfg_pre <= bus_req.wdata[CW-1:0];
        scope_pkg::reg_pst: cfg_pst <= bus_req.wdata[CW-1:0];
        scope_pkg::reg_lvl: cfg_lvl <= bus_req.wdata[scope_pkg::smp_w-1:0];
        scope_pkg::reg_hst: cfg_hst <= bus_req.wdata[scope_pkg::smp_w-1:0];
        scope_pkg::reg_avg: cfg_avg <= bus_req.wdata[0];
        scope_pkg::reg_dec: cfg_dec <= bus_req.wdata[DCW-1:0];
        scope_pkg::reg_shr: cfg_shr <= bus_req.wdata[DSW-1:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // read access
  //////////////////////////////
  always_comb begin
    case (bus_req.addr)
      // acquiring, idle, triggered
      scope_pkg::reg_ctl:        rd_mux = DW'({sts_trg, ~sts_acq, sts_acq, 1'b0});
      scope_pkg::reg_cfg:        rd_mux = DW'(cfg_con);
      scope_pkg::reg_trg:        rd_mux = DW'(cfg_trg);
      scope_pkg::reg_pre:        rd_mux = DW'(cfg_pre);
      scope_pkg::reg_pst:        rd_mux = DW'(cfg_pst);
      scope_pkg::reg_sts_pre:    rd_mux = DW'(sts_pre);
      scope_pkg::reg_sts_pst:    rd_mux = DW'(sts_pst);
      // 64-bit timestamps as word pairs
      scope_pkg::reg_cts_acq_lo: rd_mux = DW'(cts_acq);
      scope_pkg::reg_cts_acq_hi: rd_mux = DW'(cts_acq >> DW);
      scope_pkg::reg_cts_trg_lo: rd_mux = DW'(cts_trg);
      scope_pkg::reg_cts_trg_hi: rd_mux = DW'(cts_trg >> DW);
      scope_pkg::reg_cts_stp_lo: rd_mux = DW'(cts_stp);
      scope_pkg::reg_cts_stp_hi: rd_mux = DW'(cts_stp >> DW);
      // level reads back zero padded
      scope_pkg::reg_lvl:        rd_mux = DW'($unsigned(cfg_lvl));
      scope_pkg::reg_hst:        rd_mux = DW'(cfg_hst);
      scope_pkg::reg_avg:        rd_mux = DW'(cfg_avg);
      scope_pkg::reg_dec:        rd_mux = DW'(cfg_dec);
      scope_pkg::reg_shr:        rd_mux = DW'(cfg_shr);
      default:                   rd_mux = '0;
    endcase
  end

  // ack one cycle after any request
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req.wen | bus_req.ren;
    end
  end

  // read data valid with ack
  always_ff @(posedge bus) begin
    rdata_q <= bus_req.ren ? rd_mux : '0;
  end

  assign bus_rsp.ack   = ack_q;
  assign bus_rsp.rdata = rdata_q;

  // ack only after a request with exactly one of wen and ren
  a_ack_after_req: assert property (@(posedge bus) disable iff (!rst_n)
    bus_rsp.ack |-> $past(bus_req.wen ^ bus_req.ren));

endmodule

// ==== source/scope_top.sv ====
//////////////////////////////
// scope acquisition top level
// register slave, decimator,
// edge detector, acquisition
//////////////////////////////

`timescale 1ns/1ps

module scope_top #(
  parameter int unsigned DCW = 17,
  parameter int unsigned DSW = 4,
  parameter int unsigned CW  = 17,
  parameter int unsigned TN  = 4,
  parameter int unsigned TW  = 64
) (
  input  logic                bus,
  input  logic                rst_n,
  input  scope_pkg::bus_req_t bus_req,
  output scope_pkg::bus_rsp_t bus_rsp,
  input  scope_pkg::smp_t     sti,
  output scope_pkg::smp_t     sto,
  input  logic [TN-1:0]       trg_ext,
  output logic                trg_swo,
  output logic                trg_out
);

  // decimated stream
  scope_pkg::smp_t std;

  // configuration
  logic                               cfg_con;
  logic [TN+1:0]                      cfg_trg;
  logic [CW-1:0]                      cfg_pre;
  logic [CW-1:0]                      cfg_pst;
  logic signed [scope_pkg::smp_w-1:0] cfg_lvl;
  logic [scope_pkg::smp_w-1:0]        cfg_hst;
  logic                               cfg_avg;
  logic [DCW-1:0]                     cfg_dec;
  logic [DSW-1:0]                     cfg_shr;
  // control and status
  logic                               ctl_rst;
  logic                               ctl_acq;
  logic                               ctl_stp;
  logic                               sts_acq;
  logic                               sts_trg;
  logic [CW-1:0]                      sts_pre;
  logic [CW-1:0]                      sts_pst;
  logic [TW-1:0]                      cts_acq;
  logic [TW-1:0]                      cts_trg;
  logic [TW-1:0]                      cts_stp;
  // software, edge, then external
  logic [TN+1:0]                      trg_src;

  assign trg_src = {trg_ext, trg_out, trg_swo};

  //////////////////////////////
  // instances
  //////////////////////////////
  scope_regs #(.DCW(DCW), .DSW(DSW), .CW(CW), .TN(TN), .TW(TW)) i_regs (
    .bus, .rst_n, .bus_req, .bus_rsp,
    .cfg_con, .cfg_trg, .cfg_pre, .cfg_pst, .cfg_lvl, .cfg_hst,
    .cfg_avg, .cfg_dec, .cfg_shr,
    .ctl_rst, .ctl_acq, .ctl_stp, .trg_swo,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst, .cts_acq, .cts_trg, .cts_stp
  );

  scope_dec_avg #(.DCW(DCW), .DSW(DSW)) i_dec_avg (
    .bus, .rst_n, .ctl_rst, .cfg_avg, .cfg_dec, .cfg_shr,
    .sti, .sto(std)
  );

  // edge detector monitors the decimated stream
  scope_edge i_edge (
    .bus, .rst_n, .ctl_rst, .cfg_lvl, .cfg_hst, .str(std), .trg_out
  );

  scope_acq #(.CW(CW), .TN(TN), .TW(TW)) i_acq (
    .bus, .rst_n, .sti(std), .sto,
    .ctl_rst, .ctl_acq, .ctl_stp, .trg_src, .cfg_trg,
    .cfg_con, .cfg_pre, .cfg_pst,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst, .cts_acq, .cts_trg, .cts_stp
  );

endmodule

// ==== verif/scope_tb.sv ====
//////////////////////////////
// testbench for the scope top level
// clock and reset, LFSR stimulus,
// group reference model, stream and
// edge monitors, cycle timeout
//////////////////////////////

`timescale 1ns/1ps

module scope_tb;

  localparam int unsigned DCW = 17;
  localparam int unsigned DSW = 4;
  localparam int unsigned CW  = 17;
  localparam int unsigned TN  = 4;
  localparam int unsigned TW  = 64;
  localparam int unsigned SW  = scope_pkg::smp_w;

  // cycles per test: regs, dec, edge, acq, ext, rst
  localparam int unsigned cyc_limit = 2 * (120 + 300 + 300 + 250 + 250 + 150);

  logic                bus;
  logic                rst_n;
  scope_pkg::bus_req_t bus_req;
  scope_pkg::bus_rsp_t bus_rsp;
  scope_pkg::smp_t     sti;
  scope_pkg::smp_t     sto;
  logic [TN-1:0]       trg_ext;
  logic                trg_swo;
  logic                trg_out;

  int unsigned     mism_cnt;
  int unsigned     fail_cnt;
  int unsigned     cyc_cnt;
  logic [15:0]     lfsr_q;
  // reference model state
  scope_pkg::smp_t exp_q[$];
  scope_pkg::smp_t exp_beat;
  int unsigned     m_dec;
  bit              m_avg;
  int unsigned     m_shr;
  int unsigned     grp_cnt;
  longint          grp_sum;
  int              m_lvl;
  int              m_hst;
  bit              m_armed;
  bit [1:0]        trg_pipe;
  bit              edge_chk;
  int unsigned     edge_cnt;
  logic [TW-1:0]   t_acq;
  logic [TW-1:0]   t_trg;
  logic [TW-1:0]   t_stp;

  scope_top #(.DCW(DCW), .DSW(DSW), .CW(CW), .TN(TN), .TW(TW)) i_dut (
    .bus, .rst_n, .bus_req, .bus_rsp, .sti, .sto, .trg_ext, .trg_swo, .trg_out
  );

  initial begin
    bus = 1'b0;
    forever #50 bus = ~bus;
  end

  //////////////////////////////
  // helpers and reference
  //////////////////////////////
  // galois LFSR, one step per bit
  function automatic logic lfsr_step();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 16'hb400;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) r = {r[30:0], lfsr_step()};
    return r;
  endfunction

  // one output per group, shifted sum or last sample
  function automatic scope_pkg::smp_t ref_group(input longint sum,
      input logic signed [SW-1:0] last, input bit avg, input int unsigned shr);
    scope_pkg::smp_t r;
    longint          avg_v;
    avg_v = sum >>> shr;
    r.vld = 1'b1;
    r.dat = avg ? avg_v[SW-1:0] : last;
    return r;
  endfunction

  // status bits of the control word
  function automatic logic [31:0] ctl_word(input bit acq, input bit trg);
    return {28'd0, trg, !acq, acq, 1'b0};
  endfunction

  function automatic logic [31:0] field_mask(input int unsigned w);
    return (32'd1 << w) - 32'd1;
  endfunction

  task automatic check_smp(input scope_pkg::smp_t got, input scope_pkg::smp_t exp,
      input string what);
    if (got !== exp) begin
      mism_cnt++;
      $display("MISMATCH at %0t ns: %s got vld=%b dat=%0d, expected vld=%b dat=%0d",
               $time, what, got.vld, got.dat, exp.vld, exp.dat);
    end
  endtask

  task automatic check_rsp(input scope_pkg::bus_rsp_t got, input scope_pkg::bus_rsp_t exp,
      input string what);
    if (got !== exp) begin
      mism_cnt++;
      $display("MISMATCH at %0t ns: %s got ack=%b rdata=%h, expected ack=%b rdata=%h",
               $time, what, got.ack, got.rdata, exp.ack, exp.rdata);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      mism_cnt++;
      $display("MISMATCH at %0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // bus and stream drivers
  //////////////////////////////
  // one request, response sampled mid cycle
  task automatic bus_rw(input logic wr, input logic [scope_pkg::bus_aw-1:0] addr,
      input logic [31:0] wdata, output scope_pkg::bus_rsp_t rsp);
    @(posedge bus);
    #1;
    bus_req.wen   = wr;
    bus_req.ren   = !wr;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    @(negedge bus);
    check_bit(bus_rsp.ack, 1'b0, "ack in request cycle");
    // software trigger strobe only with its control bit, same cycle as wen
    check_bit(trg_swo,
              wr && (addr == scope_pkg::reg_ctl) && wdata[scope_pkg::ctl_bit_trg],
              "software trigger strobe");
    @(posedge bus);
    #1;
    bus_req = '0;
    @(negedge bus);
    rsp = bus_rsp;
    check_bit(trg_swo, 1'b0, "software trigger strobe after request");
  endtask

  // write and keep the model config in step
  task automatic wr_reg(input logic [scope_pkg::bus_aw-1:0] addr, input logic [31:0] data);
    scope_pkg::bus_rsp_t rsp;
    bus_rw(1'b1, addr, data, rsp);
    check_bit(rsp.ack, 1'b1, "write ack");
    case (addr)
      scope_pkg::reg_dec: m_dec = data[DCW-1:0];
      scope_pkg::reg_avg: m_avg = data[0];
      scope_pkg::reg_shr: m_shr = data[DSW-1:0];
      scope_pkg::reg_lvl: m_lvl = $signed(data[SW-1:0]);
      scope_pkg::reg_hst: m_hst = data[SW-1:0];
      default: ;
    endcase
    // control reset restarts groups and the edge detector
    if (addr == scope_pkg::reg_ctl && data[scope_pkg::ctl_bit_rst]) begin
      grp_cnt = 0;
      grp_sum = 0;
      m_armed = 1'b0;
    end
  endtask

  task automatic rd_chk(input logic [scope_pkg::bus_aw-1:0] addr, input logic [31:0] exp);
    scope_pkg::bus_rsp_t rsp;
    bus_rw(1'b0, addr, '0, rsp);
    check_rsp(rsp, {1'b1, exp}, $sformatf("read of 0x%02h", addr));
  endtask

  // 64-bit timestamp as lo and hi words
  task automatic rd_ts(input logic [scope_pkg::bus_aw-1:0] addr, output logic [TW-1:0] ts);
    scope_pkg::bus_rsp_t rsp;
    bus_rw(1'b0, addr, '0, rsp);
    check_bit(rsp.ack, 1'b1, "timestamp ack");
    ts[31:0] = rsp.rdata;
    bus_rw(1'b0, addr + 7'h4, '0, rsp);
    check_bit(rsp.ack, 1'b1, "timestamp ack");
    ts[63:32] = rsp.rdata;
  endtask

  task automatic wr_rd(input logic [scope_pkg::bus_aw-1:0] addr, input int unsigned w,
      input logic [31:0] data);
    wr_reg(addr, data);
    rd_chk(addr, data & field_mask(w));
  endtask

  task automatic setup(input int unsigned dec, input bit avg, input int unsigned shr,
      input bit con, input logic [31:0] trg, input int unsigned pre, input int unsigned pst);
    wr_reg(scope_pkg::reg_dec, dec);
    wr_reg(scope_pkg::reg_avg, avg);
    wr_reg(scope_pkg::reg_shr, shr);
    wr_reg(scope_pkg::reg_cfg, con);
    wr_reg(scope_pkg::reg_trg, trg);
    wr_reg(scope_pkg::reg_pre, pre);
    wr_reg(scope_pkg::reg_pst, pst);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_rst);
  endtask

  // beat with random gap, gap 0 is back to back
  task automatic send_smp(input logic signed [SW-1:0] v);
    int unsigned gap;
    @(posedge bus);
    #1;
    sti.vld = 1'b1;
    sti.dat = v;
    gap = rand_bits(2);
    if (gap != 0) begin
      @(posedge bus);
      #1;
      sti.vld = 1'b0;
      repeat (gap - 1) @(posedge bus);
    end
  endtask

  // fwd says whether the group output leaves on sto
  task automatic feed(input logic signed [SW-1:0] v, input bit fwd);
    grp_sum += v;
    grp_cnt++;
    if (grp_cnt >= ((m_dec == 0) ? 1 : m_dec)) begin
      if (fwd) exp_q.push_back(ref_group(grp_sum, v, m_avg, m_shr));
      grp_cnt = 0;
      grp_sum = 0;
    end
    send_smp(v);
  endtask

  task automatic feed_rand(input int unsigned n, input int unsigned n_fwd);
    logic [31:0] r;
    for (int unsigned i = 0; i < n; i++) begin
      r = rand_bits(SW);
      feed(r[SW-1:0], i < n_fwd);
    end
  endtask

  task automatic quiet(input int unsigned n);
    @(posedge bus);
    #1;
    sti.vld = 1'b0;
    repeat (n) @(posedge bus);
  endtask

  // wait for every expected beat, then a few idle cycles
  task automatic drain();
    while (exp_q.size() != 0) @(posedge bus);
    repeat (4) @(posedge bus);
  endtask

  task automatic pulse_ext(input int unsigned idx);
    @(posedge bus);
    #1;
    trg_ext[idx] = 1'b1;
    @(posedge bus);
    #1;
    trg_ext = '0;
  endtask

  //////////////////////////////
  // monitors and timeout
  //////////////////////////////
  // every sto beat against the expected queue
  always @(negedge bus) begin
    if (rst_n && sto.vld) begin
      if (exp_q.size() == 0) begin
        fail_cnt++;
        $display("at %0t ns the DUT sent an output beat that was not expected", $time);
      end else begin
        exp_beat = exp_q.pop_front();
        check_smp(sto, exp_beat, "output beat");
      end
    end
  end

  // schmitt model on input beats, strobe two cycles later with N = 1
  always @(negedge bus) begin
    if (edge_chk) begin
      check_bit(trg_out, trg_pipe[1], "edge strobe");
      if (trg_out) edge_cnt++;
    end
    trg_pipe = {trg_pipe[0], 1'b0};
    if (sti.vld) begin
      if (m_armed && int'(sti.dat) >= m_lvl) begin
        trg_pipe[0] = 1'b1;
        m_armed     = 1'b0;
      end else if (int'(sti.dat) < m_lvl - m_hst) begin
        m_armed = 1'b1;
      end
    end
  end

  always @(posedge bus) begin
    cyc_cnt++;
    if (cyc_cnt >= cyc_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cyc_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    rst_n    = 1'b0;
    bus_req  = '0;
    sti      = '0;
    trg_ext  = '0;
    lfsr_q   = 16'd88;
    mism_cnt = 0;
    fail_cnt = 0;
    cyc_cnt  = 0;
    m_dec    = 0;
    m_avg    = 1'b0;
    m_shr    = 0;
    m_lvl    = 0;
    m_hst    = 0;
    m_armed  = 1'b0;
    grp_cnt  = 0;
    grp_sum  = 0;
    trg_pipe = '0;
    edge_chk = 1'b0;
    edge_cnt = 0;
    repeat (5) @(posedge bus);
    #1;
    rst_n = 1'b1;

    // registers, status and unmapped offsets
    rd_chk(scope_pkg::reg_ctl, ctl_word(1'b0, 1'b0));
    rd_chk(scope_pkg::reg_sts_pre, 0);
    rd_chk(scope_pkg::reg_sts_pst, 0);
    rd_chk(7'h40, 0);
    rd_chk(7'h7c, 0);
    for (int k = 0; k < 2; k++) begin
      wr_rd(scope_pkg::reg_cfg, 1, (k == 0) ? 32'hffff_ffff : 32'h5a5a_a5a4);
      wr_rd(scope_pkg::reg_trg, TN + 2, (k == 0) ? 32'hffff_ffff : 32'h5a5a_a5a5);
      wr_rd(scope_pkg::reg_pre, CW, (k == 0) ? 32'hffff_ffff : 32'h5a5a_a5a5);
      wr_rd(scope_pkg::reg_pst, CW, (k == 0) ? 32'hffff_ffff : 32'ha5a5_5a5a);
      wr_rd(scope_pkg::reg_lvl, SW, (k == 0) ? 32'hffff_ffff : 32'h5a5a_a5a5);
      wr_rd(scope_pkg::reg_hst, SW, (k == 0) ? 32'hffff_ffff : 32'ha5a5_5a5a);
      wr_rd(scope_pkg::reg_avg, 1, (k == 0) ? 32'hffff_ffff : 32'h5a5a_a5a4);
      wr_rd(scope_pkg::reg_dec, DCW, (k == 0) ? 32'hffff_ffff : 32'h5a5a_a5a5);
      wr_rd(scope_pkg::reg_shr, DSW, (k == 0) ? 32'hffff_ffff : 32'h5a5a_a5a5);
    end

    // decimation by 4, plain then averaged
    setup(4, 1'b0, 0, 1'b1, 0, 0, 0);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_acq);
    feed_rand(16, 16);
    quiet(4);
    drain();
    wr_reg(scope_pkg::reg_avg, 1);
    wr_reg(scope_pkg::reg_shr, 2);
    feed_rand(16, 16);
    quiet(4);
    drain();
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_stp);

    // edge detector, two rising crossings then ripple
    setup(1, 1'b0, 0, 1'b0, 0, 0, 0);
    wr_reg(scope_pkg::reg_lvl, 100);
    wr_reg(scope_pkg::reg_hst, 20);
    edge_cnt = 0;
    edge_chk = 1'b1;
    for (int v = 40; v <= 160; v += 10) feed(v, 1'b0);
    for (int v = 150; v >= 40; v -= 10) feed(v, 1'b0);
    for (int v = 50; v <= 160; v += 10) feed(v, 1'b0);
    for (int i = 0; i < 10; i++) feed((i % 2) ? 105 : 95, 1'b0);
    quiet(4);
    edge_chk = 1'b0;
    if (edge_cnt != 2) begin
      fail_cnt++;
      $display("expected two edge strobes for two crossings, saw %0d", edge_cnt);
    end

    // pre 8, post 16, software trigger sent early
    setup(1, 1'b0, 0, 1'b0, 32'h1, 8, 16);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_acq);
    feed_rand(4, 4);
    quiet(4);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_trg);
    rd_chk(scope_pkg::reg_ctl, ctl_word(1'b1, 1'b0));
    feed_rand(4, 4);
    quiet(4);
    rd_chk(scope_pkg::reg_sts_pre, 8);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_trg);
    rd_chk(scope_pkg::reg_ctl, ctl_word(1'b1, 1'b1));
    feed_rand(20, 16);
    quiet(4);
    drain();
    rd_chk(scope_pkg::reg_ctl, ctl_word(1'b0, 1'b1));
    rd_chk(scope_pkg::reg_sts_pre, 8);
    rd_chk(scope_pkg::reg_sts_pst, 16);

    // external trigger gated by its mask bit
    setup(1, 1'b0, 0, 1'b0, 32'h1, 2, 4);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_acq);
    feed_rand(2, 2);
    quiet(4);
    pulse_ext(0);
    rd_chk(scope_pkg::reg_ctl, ctl_word(1'b1, 1'b0));
    wr_reg(scope_pkg::reg_trg, 32'h5);
    pulse_ext(0);
    rd_chk(scope_pkg::reg_ctl, ctl_word(1'b1, 1'b1));
    feed_rand(4, 4);
    quiet(4);
    drain();
    rd_chk(scope_pkg::reg_ctl, ctl_word(1'b0, 1'b1));
    rd_chk(scope_pkg::reg_sts_pst, 4);
    // continuous mode runs past the post count
    wr_reg(scope_pkg::reg_cfg, 1);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_acq);
    feed_rand(2, 2);
    quiet(4);
    pulse_ext(0);
    feed_rand(8, 8);
    quiet(4);
    drain();
    rd_chk(scope_pkg::reg_ctl, ctl_word(1'b1, 1'b1));
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_stp);
    rd_chk(scope_pkg::reg_ctl, ctl_word(1'b0, 1'b1));
    rd_ts(scope_pkg::reg_cts_acq_lo, t_acq);
    rd_ts(scope_pkg::reg_cts_trg_lo, t_trg);
    rd_ts(scope_pkg::reg_cts_stp_lo, t_stp);
    if (!(t_acq < t_trg && t_trg < t_stp)) begin
      fail_cnt++;
      $display("timestamps out of order: start %0d, trigger %0d, stop %0d",
               t_acq, t_trg, t_stp);
    end

    // control reset in the middle of a group
    setup(4, 1'b1, 0, 1'b1, 0, 0, 0);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_acq);
    feed_rand(2, 0);
    quiet(4);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_rst);
    wr_reg(scope_pkg::reg_ctl, 32'd1 << scope_pkg::ctl_bit_acq);
    feed_rand(8, 8);
    quiet(4);
    drain();

    $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt + fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
